// ==== tb.f ====
source/gemac_pkg.sv
source/mdio_clkgen.sv
source/mdio_ctrl.sv
source/mdio_shift.sv
source/eth_miim.sv
source/gemac_wb.sv
verification/mdio_phy_model.sv
verification/tb_gemac_wb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build with Verilator, run into sim.log, then search the log for the fail message
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module tb_gemac_wb -f tb.f -o tb_gemac_wb \
   && ./obj_dir/tb_gemac_wb > sim.log 2>&1 \
   || { cat sim.log 2>/dev/null; echo "Build or simulation run did not complete"; exit 1; }
cat sim.log
grep -q "Simulation FAILED" sim.log && exit 1
grep -q "Simulation PASSED" sim.log || exit 1

// ==== verification/tb_gemac_wb.sv ====
module tb_gemac_wb;
   import gemac_pkg::*;

   logic                  wb_clk;
   logic                  wb_rst;
   logic                  wb_cyc;
   logic                  wb_stb;
   logic                  wb_we;
   logic [WB_AW-1:0]      wb_adr;
   logic [WB_DW-1:0]      wb_dat_w;
   logic [WB_DW-1:0]      wb_dat_r;
   logic                  wb_ack;
   wire                   mdio;
   logic                  mdc;
   logic [MAC_AW-1:0]     ucast_addr;
   logic [MAC_AW-1:0]     mcast_addr;
   logic [SETTINGS_W-1:0] flags;
   int                    phy_wr_cnt;
   logic [PHY_AW-1:0]     phy_wr_fiad;
   logic [PHY_AW-1:0]     phy_wr_rgad;
   logic [MII_DW-1:0]     phy_wr_data;

   integer                seed;
   int                    errors = 0;
   int                    mark = 0;
   int                    tests_run = 0;
   int                    tests_failed = 0;
   int                    cycle_no = 0;
   logic                  timed_out = 1'b0;
   string                 timeout_msg;
   logic [MII_DW-1:0]     shadow [0:1023];       // Data written to the PHY
   logic                  shadow_valid [0:1023] = '{default: 1'b0};

   pullup (mdio);

   gemac_wb uut
   (
      .wb_clk       (wb_clk),
      .wb_rst       (wb_rst),
      .wb_cyc_i     (wb_cyc),
      .wb_stb_i     (wb_stb),
      .wb_we_i      (wb_we),
      .wb_adr_i     (wb_adr),
      .wb_dat_i     (wb_dat_w),
      .wb_dat_o     (wb_dat_r),
      .wb_ack_o     (wb_ack),
      .mdio_io      (mdio),
      .mdc_o        (mdc),
      .ucast_addr_o (ucast_addr),
      .mcast_addr_o (mcast_addr),
      .pass_ucast_o (flags[5]),
      .pass_mcast_o (flags[4]),
      .pass_bcast_o (flags[3]),
      .pass_pause_o (flags[2]),
      .pass_all_o   (flags[1]),
      .pause_en_o   (flags[0])
   );

   mdio_phy_model phy
   (
      .mdc_i     (mdc),
      .mdio_io   (mdio),
      .wr_cnt_o  (phy_wr_cnt),
      .wr_fiad_o (phy_wr_fiad),
      .wr_rgad_o (phy_wr_rgad),
      .wr_data_o (phy_wr_data)
   );

   initial
   begin
      wb_clk = 1'b0;
      forever #5 wb_clk = ~wb_clk;
   end

   always @(posedge wb_clk)
      cycle_no <= cycle_no + 1;

   // Ends the run when any wait runs out
   initial
   begin
      wait (timed_out);
      $display("Timeout: %s", timeout_msg);
      $display("Simulation FAILED");
      $finish;
   end

   function automatic logic [MII_DW-1:0] phy_value(input logic [PHY_AW-1:0] fiad,
                                                   input logic [PHY_AW-1:0] rgad);
      return {fiad, 1'b1, rgad, rgad};
   endfunction

   function automatic logic [MII_DW-1:0] expected_read(input logic [PHY_AW-1:0] fiad,
                                                       input logic [PHY_AW-1:0] rgad);
      if (shadow_valid[{fiad, rgad}])
         return shadow[{fiad, rgad}];
      return phy_value(fiad, rgad);
   endfunction

   function automatic logic [WB_DW-1:0] reg_mask(input int word);
      case (word)
         0:       return 32'h0000_003f;
         1, 3, 7: return 32'h0000_ffff;
         2, 4:    return 32'hffff_ffff;
         5:       return 32'h0000_01ff;
         6:       return 32'h0000_1f1f;          // Register and PHY address fields
         default: return 32'h0;
      endcase
   endfunction

   task automatic halt_on_timeout(input string what);
      timeout_msg = what;
      timed_out   = 1'b1;
      forever @(posedge wb_clk);
   endtask

   task automatic wb_access(input logic we, input logic [REG_AW-1:0] word,
                            input logic [WB_DW-1:0] wdata, output logic [WB_DW-1:0] rdata);
      int n;
      @(posedge wb_clk);
      #1;
      wb_cyc   = 1'b1;
      wb_stb   = 1'b1;
      wb_we    = we;
      wb_adr   = {word, 2'b00};
      wb_dat_w = wdata;
      n = 0;
      do
      begin
         @(posedge wb_clk);
         #1;
         n++;
      end while (!wb_ack && n < 16);
      rdata  = wb_dat_r;
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      wb_we  = 1'b0;
      if (!wb_ack)
         halt_on_timeout($sformatf("no Wishbone ack at register %0d", word));
   endtask

   task automatic wb_write(input logic [REG_AW-1:0] word, input logic [WB_DW-1:0] data);
      logic [WB_DW-1:0] unused;
      wb_access(1'b1, word, data, unused);
   endtask

   task automatic wb_read(input logic [REG_AW-1:0] word, output logic [WB_DW-1:0] data);
      wb_access(1'b0, word, '0, data);
   endtask

   task automatic check_word(input string what, input logic [WB_DW-1:0] got,
                             input logic [WB_DW-1:0] exp);
      if (got !== exp)
      begin
         $display("** Error at time %0t: %s is %h, expected %h", $time, what, got, exp);
         errors++;
      end
   endtask

   task automatic check_mii(input string what, input logic [MII_DW-1:0] got,
                            input logic [MII_DW-1:0] exp);
      if (got !== exp)
      begin
         $display("** Error at time %0t: %s is %h, expected %h", $time, what, got, exp);
         errors++;
      end
   endtask

   // Counts wb_clk cycles until MDC shows the given level
   task automatic wait_mdc(input logic level, output int cycles);
      cycles = 0;
      do
      begin
         @(posedge wb_clk);
         #1;
         cycles++;
      end while (mdc !== level && cycles < 1024);
      if (mdc !== level)
         halt_on_timeout("MDC stopped toggling");
   endtask

   // Each MDC half period lasts one divider count of wb_clk cycles
   task automatic check_mdc(input int half);
      int n;
      int lo;
      int hi;
      wait_mdc(1'b1, n);
      wait_mdc(1'b0, n);
      wait_mdc(1'b1, lo);
      wait_mdc(1'b0, hi);
      check_word("MDC low cycles", lo, half);
      check_word("MDC high cycles", hi, half);
   endtask

   // Polls the status register until the masked bits match
   task automatic wait_status(input logic [WB_DW-1:0] mask, input logic [WB_DW-1:0] value,
                              input string what);
      logic [WB_DW-1:0] st;
      int               start;
      start = cycle_no;
      wb_read(REG_MIISTATUS, st);
      while ((st & mask) != value)
      begin
         if (cycle_no - start > 4000)
            halt_on_timeout(what);
         wb_read(REG_MIISTATUS, st);
      end
   endtask

   task automatic run_phy_read(input logic [PHY_AW-1:0] fiad, input logic [PHY_AW-1:0] rgad);
      logic [WB_DW-1:0] rd;
      wb_write(REG_MIIADDR, {19'd0, rgad, 3'd0, fiad});
      wb_write(REG_MIICMD, 32'h2);
      wait_status(32'h2, 32'h2, "busy never rose on PHY read");
      wait_status(32'h2, 32'h0, "busy stuck high on PHY read");
      wb_read(REG_MIIRXDATA, rd);
      check_mii("PHY read data", rd[MII_DW-1:0], expected_read(fiad, rgad));
      wb_read(REG_MIICMD, rd);
      check_word("command after read", rd, '0);
   endtask

   task automatic report_test(input string name);
      int n;
      n    = errors - mark;
      mark = errors;
      tests_run++;
      if (n == 0)
         $display("Test %0d %s: passed", tests_run, name);
      else
      begin
         tests_failed++;
         $display("Test %0d %s: failed with %0d errors", tests_run, name, n);
      end
   endtask

   initial
   begin
      logic [WB_DW-1:0]  rd;
      logic [WB_DW-1:0]  rnd;
      logic [WB_DW-1:0]  wdata [0:7];
      logic [PHY_AW-1:0] fiad;
      logic [PHY_AW-1:0] rgad;
      logic [MII_DW-1:0] data;
      logic [MII_DW-1:0] exp;
      int                cnt_before;
      seed     = 32'hf69e_678e;
      wb_rst   = 1'b1;
      wb_cyc   = 1'b0;
      wb_stb   = 1'b0;
      wb_we    = 1'b0;
      wb_adr   = '0;
      wb_dat_w = '0;
      repeat (2) @(posedge wb_clk);
      #1;
      wb_rst = 1'b0;

      wb_read(REG_SETTINGS, rd);
      check_word("settings", rd, WB_DW'(6'b111001));
      check_word("filter flags", WB_DW'(flags), WB_DW'(6'b111001));
      for (int i = 1; i <= 10; i++)
      begin
         wb_read(REG_AW'(i), rd);
         check_word($sformatf("register %0d", i), rd, '0);
      end
      report_test("reset values");

      for (int i = 0; i < 8; i++)
      begin
         wdata[i] = $random(seed);
         wb_write(REG_AW'(i), wdata[i]);
      end
      for (int i = 0; i < 8; i++)
      begin
         wb_read(REG_AW'(i), rd);
         check_word($sformatf("register %0d", i), rd, wdata[i] & reg_mask(i));
      end
      check_word("filter flags", WB_DW'(flags), wdata[0] & reg_mask(0));
      check_word("ucast_addr_o high", WB_DW'(ucast_addr[47:32]), wdata[1] & reg_mask(1));
      check_word("ucast_addr_o low", ucast_addr[31:0], wdata[2]);
      check_word("mcast_addr_o high", WB_DW'(mcast_addr[47:32]), wdata[3] & reg_mask(3));
      check_word("mcast_addr_o low", mcast_addr[31:0], wdata[4]);
      report_test("register write and read back");

      rnd  = $random(seed);
      fiad = rnd[4:0];
      rgad = rnd[12:8];
      data = rnd[31:16];
      wb_write(REG_MIIMODER, 32'd4);
      check_mdc(4);
      wb_write(REG_MIIADDR, {19'd0, rgad, 3'd0, fiad});
      wb_write(REG_MIIDATA, {16'd0, data});
      cnt_before = phy_wr_cnt;
      shadow[{fiad, rgad}]       = data;
      shadow_valid[{fiad, rgad}] = 1'b1;
      wb_write(REG_MIICMD, 32'h4);
      wait_status(32'h2, 32'h2, "busy never rose on PHY write");
      wait_status(32'h2, 32'h0, "busy stuck high on PHY write");
      wb_read(REG_MIICMD, rd);
      check_word("command after write", rd, '0);
      check_word("PHY write count", WB_DW'(phy_wr_cnt - cnt_before), 32'd1);
      check_word("PHY write address", WB_DW'({phy_wr_rgad, 3'd0, phy_wr_fiad}),
                 WB_DW'({rgad, 3'd0, fiad}));
      check_mii("PHY write data", phy_wr_data, data);
      report_test("PHY write");

      run_phy_read(fiad, rgad);
      wb_write(REG_MIIMODER, 32'h106);           // NoPre, divider 6
      check_mdc(6);
      run_phy_read(fiad, rgad ^ 5'h0a);
      report_test("PHY read");

      fiad = fiad ^ 5'h01;
      exp  = expected_read(fiad, 5'd1);
      wb_write(REG_MIIMODER, 32'd8);
      wb_write(REG_MIIADDR, {19'd0, 5'd1, 3'd0, fiad});
      wb_write(REG_MIICMD, 32'h1);
      wait_status(32'h4, 32'h4, "Nvalid never rose during scan");
      wait_status(32'h4, 32'h0, "Nvalid stuck high during scan");
      wb_read(REG_MIISTATUS, rd);
      check_word("LinkFail", rd & 32'h1, {31'd0, ~exp[2]});
      wb_read(REG_MIIRXDATA, rd);
      check_mii("scan data", rd[MII_DW-1:0], exp);
      wb_write(REG_MIICMD, 32'h0);
      wait_status(32'h2, 32'h0, "busy stuck high after scan stop");
      repeat (20)
      begin
         wb_read(REG_MIISTATUS, rd);
         check_word("busy after scan stop", rd & 32'h2, 32'h0);
      end
      report_test("PHY scan");

      $display("Tests run: %0d, tests failed: %0d, errors: %0d", tests_run, tests_failed, errors);
      if (errors == 0)
         $display("Simulation PASSED");
      else
         $display("Simulation FAILED");
      $finish;
   end

endmodule

// ==== verification/mdio_phy_model.sv ====
module mdio_phy_model
(
   input  logic                         mdc_i,
   inout  wire                          mdio_io,
   output int                           wr_cnt_o,
   output logic [gemac_pkg::PHY_AW-1:0] wr_fiad_o,
   output logic [gemac_pkg::PHY_AW-1:0] wr_rgad_o,
   output logic [gemac_pkg::MII_DW-1:0] wr_data_o
);
   import gemac_pkg::*;

   logic [MII_DW-1:0] mem [0:1023];              // Indexed by {fiad, rgad}
   logic              written [0:1023] = '{default: 1'b0};
   logic              active = 1'b0;
   logic              rd_active = 1'b0;
   logic              drv_en = 1'b0;
   logic              drv_bit = 1'b1;
   logic [5:0]        bit_cnt = 6'd0;
   logic [31:0]       frame = 32'd0;
   logic [MII_DW-1:0] rd_word = '0;
   int                wr_cnt = 0;

   // Register contents before any write
   function automatic logic [MII_DW-1:0] reg_default(input logic [PHY_AW-1:0] fiad,
                                                     input logic [PHY_AW-1:0] rgad);
      return {fiad, 1'b1, rgad, rgad};
   endfunction

   assign mdio_io  = drv_en ? drv_bit : 1'bz;
   assign wr_cnt_o = wr_cnt;

   always @(posedge mdc_i)
   begin
      if (!active)
      begin
         if (mdio_io === 1'b0)                   // Start bit ends the idle ones
         begin
            active  = 1'b1;
            bit_cnt = 6'd1;
            frame   = 32'd0;
         end
      end
      else
      begin
         frame = {frame[30:0], mdio_io};
         if (bit_cnt == 6'd13 && frame[11:10] == 2'b10)
         begin
            rd_word   = written[frame[9:0]] ? mem[frame[9:0]] : reg_default(frame[9:5], frame[4:0]);
            rd_active = 1'b1;
         end
         if (bit_cnt == 6'd31)
         begin
            if (frame[29:28] == 2'b01)           // Write opcode
            begin
               mem[frame[27:18]]     = frame[15:0];
               written[frame[27:18]] = 1'b1;
               wr_fiad_o = frame[27:23];
               wr_rgad_o = frame[22:18];
               wr_data_o = frame[15:0];
               wr_cnt    = wr_cnt + 1;
            end
            active    = 1'b0;
            rd_active = 1'b0;
         end
         bit_cnt = bit_cnt + 6'd1;
      end
   end

   // Read data goes out on falling MDC, second turnaround bit is zero
   always @(negedge mdc_i)
   begin
      if (rd_active && bit_cnt == 6'd15)
      begin
         drv_en  = 1'b1;
         drv_bit = 1'b0;
      end
      else if (rd_active && bit_cnt >= 6'd16)
      begin
         drv_en  = 1'b1;
         drv_bit = rd_word[MII_DW-1];
         rd_word = {rd_word[MII_DW-2:0], 1'b0};
      end
      else
         drv_en = 1'b0;
   end

endmodule

// ==== source/gemac_wb.sv ====
module gemac_wb
(
   input  logic                          wb_clk,
   input  logic                          wb_rst,
   input  logic                          wb_cyc_i,
   input  logic                          wb_stb_i,
   input  logic                          wb_we_i,
   input  logic [gemac_pkg::WB_AW-1:0]   wb_adr_i,
   input  logic [gemac_pkg::WB_DW-1:0]   wb_dat_i,
   output logic [gemac_pkg::WB_DW-1:0]   wb_dat_o,
   output logic                          wb_ack_o,
   inout  wire                           mdio_io,
   output logic                          mdc_o,
   output logic [gemac_pkg::MAC_AW-1:0]  ucast_addr_o,
   output logic [gemac_pkg::MAC_AW-1:0]  mcast_addr_o,
   output logic                          pass_ucast_o,
   output logic                          pass_mcast_o,
   output logic                          pass_bcast_o,
   output logic                          pass_pause_o,
   output logic                          pass_all_o,
   output logic                          pause_en_o
);
   import gemac_pkg::*;

   logic                  acc;
   logic                  wr_acc;
   logic [REG_AW-1:0]     word_adr;
   logic [WB_DW-1:0]      rd_data;
   logic [SETTINGS_W-1:0] settings;
   logic                  nopre;
   logic [DIV_W-1:0]      divider;
   logic [PHY_AW-1:0]     rgad;
   logic [PHY_AW-1:0]     fiad;
   logic [MII_DW-1:0]     ctrl_data;
   logic [CMD_W-1:0]      cmd;
   logic [MII_DW-1:0]     rx_data;
   logic [MII_DW-1:0]     prsd;
   logic                  busy;
   logic                  nvalid;
   logic                  link_fail;
   logic                  wctrl_start;
   logic                  rstat_start;
   logic                  update_rx;

   assign acc      = wb_cyc_i & wb_stb_i;
   assign wr_acc   = acc & wb_we_i & ~wb_ack_o;  // Once per access
   assign word_adr = wb_adr_i[WB_AW-1:2];

   assign {pass_ucast_o, pass_mcast_o, pass_bcast_o,
           pass_pause_o, pass_all_o, pause_en_o} = settings;

   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
         wb_ack_o <= 1'b0;
      else
         wb_ack_o <= acc & ~wb_ack_o;            // Single-cycle ack
   end

   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
      begin
         settings     <= SETTINGS_DEFAULT;
         ucast_addr_o <= '0;
         mcast_addr_o <= '0;
         nopre        <= 1'b0;
         divider      <= '0;
         rgad         <= '0;
         fiad         <= '0;
         ctrl_data    <= '0;
      end
      else if (wr_acc)
      begin
         case (word_adr)
            REG_SETTINGS: settings <= wb_dat_i[SETTINGS_W-1:0];
            REG_UCAST_H:  ucast_addr_o[MAC_AW-1:WB_DW] <= wb_dat_i[MAC_AW-WB_DW-1:0];
            REG_UCAST_L:  ucast_addr_o[WB_DW-1:0] <= wb_dat_i;
            REG_MCAST_H:  mcast_addr_o[MAC_AW-1:WB_DW] <= wb_dat_i[MAC_AW-WB_DW-1:0];
            REG_MCAST_L:  mcast_addr_o[WB_DW-1:0] <= wb_dat_i;
            REG_MIIMODER: {nopre, divider} <= wb_dat_i[DIV_W:0];
            REG_MIIADDR:
            begin
               rgad <= wb_dat_i[8 +: PHY_AW];
               fiad <= wb_dat_i[PHY_AW-1:0];
            end
            REG_MIIDATA:  ctrl_data <= wb_dat_i[MII_DW-1:0];
            default:      ;
         endcase
      end
   end

   // Command bits clear themselves when the engine takes them
   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
         cmd <= '0;
      else if (wr_acc && (word_adr == REG_MIICMD))
         cmd <= wb_dat_i[CMD_W-1:0];
      else
      begin
         if (wctrl_start)
            cmd[2] <= 1'b0;
         if (rstat_start)
            cmd[1] <= 1'b0;
      end
   end

   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
         rx_data <= '0;
      else if (update_rx)
         rx_data <= prsd;                        // Last read or scan result
   end

   always_comb
   begin
      case (word_adr)
         REG_SETTINGS:  rd_data = WB_DW'(settings);
         REG_UCAST_H:   rd_data = WB_DW'(ucast_addr_o[MAC_AW-1:WB_DW]);
         REG_UCAST_L:   rd_data = ucast_addr_o[WB_DW-1:0];
         REG_MCAST_H:   rd_data = WB_DW'(mcast_addr_o[MAC_AW-1:WB_DW]);
         REG_MCAST_L:   rd_data = mcast_addr_o[WB_DW-1:0];
         REG_MIIMODER:  rd_data = WB_DW'({nopre, divider});
         REG_MIIADDR:   rd_data = WB_DW'({rgad, 3'b000, fiad});
         REG_MIIDATA:   rd_data = WB_DW'(ctrl_data);
         REG_MIICMD:    rd_data = WB_DW'(cmd);
         REG_MIISTATUS: rd_data = WB_DW'({nvalid, busy, link_fail});
         REG_MIIRXDATA: rd_data = WB_DW'(rx_data);
         default:       rd_data = '0;
      endcase
   end

   always_ff @(posedge wb_clk)
   begin
      if (acc & ~wb_ack_o)
         wb_dat_o <= rd_data;                    // Valid in the ack cycle
   end

   eth_miim u_miim
   (
      .wb_clk        (wb_clk),
      .wb_rst        (wb_rst),
      .divider_i     (divider),
      .nopre_i       (nopre),
      .ctrl_data_i   (ctrl_data),
      .rgad_i        (rgad),
      .fiad_i        (fiad),
      .wctrl_i       (cmd[2]),
      .rstat_i       (cmd[1]),
      .scan_i        (cmd[0]),
      .mdio_io       (mdio_io),
      .mdc_o         (mdc_o),
      .busy_o        (busy),
      .nvalid_o      (nvalid),
      .link_fail_o   (link_fail),
      .prsd_o        (prsd),
      .wctrl_start_o (wctrl_start),
      .rstat_start_o (rstat_start),
      .update_rx_o   (update_rx)
   );

endmodule

// ==== source/eth_miim.sv ====
module eth_miim
(
   input  logic                         wb_clk,
   input  logic                         wb_rst,
   input  logic [gemac_pkg::DIV_W-1:0]  divider_i,
   input  logic                         nopre_i,
   input  logic [gemac_pkg::MII_DW-1:0] ctrl_data_i,
   input  logic [gemac_pkg::PHY_AW-1:0] rgad_i,
   input  logic [gemac_pkg::PHY_AW-1:0] fiad_i,
   input  logic                         wctrl_i,
   input  logic                         rstat_i,
   input  logic                         scan_i,
   inout  wire                          mdio_io,
   output logic                         mdc_o,
   output logic                         busy_o,
   output logic                         nvalid_o,
   output logic                         link_fail_o,
   output logic [gemac_pkg::MII_DW-1:0] prsd_o,
   output logic                         wctrl_start_o,
   output logic                         rstat_start_o,
   output logic                         update_rx_o
);

   logic mdc_rise;
   logic mdc_fall;
   logic load;
   logic op_read;
   logic shift_en;
   logic sample_en;
   logic out_en;
   logic mdio_out;
   logic mdio_in_q;

   assign mdio_io = out_en ? mdio_out : 1'bz;   // Released for turnaround and idle

   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
         mdio_in_q <= 1'b1;
      else
         mdio_in_q <= mdio_io;                   // One stage before sampling
   end

   mdio_clkgen u_clkgen
   (
      .wb_clk     (wb_clk),
      .wb_rst     (wb_rst),
      .divider_i  (divider_i),
      .mdc_o      (mdc_o),
      .mdc_rise_o (mdc_rise),
      .mdc_fall_o (mdc_fall)
   );

   mdio_ctrl u_ctrl
   (
      .wb_clk        (wb_clk),
      .wb_rst        (wb_rst),
      .mdc_rise_i    (mdc_rise),
      .mdc_fall_i    (mdc_fall),
      .nopre_i       (nopre_i),
      .wctrl_i       (wctrl_i),
      .rstat_i       (rstat_i),
      .scan_i        (scan_i),
      .rx_bit2_i     (prsd_o[2]),
      .load_o        (load),
      .op_read_o     (op_read),
      .shift_en_o    (shift_en),
      .sample_en_o   (sample_en),
      .out_en_o      (out_en),
      .busy_o        (busy_o),
      .nvalid_o      (nvalid_o),
      .link_fail_o   (link_fail_o),
      .wctrl_start_o (wctrl_start_o),
      .rstat_start_o (rstat_start_o),
      .update_rx_o   (update_rx_o)
   );

   mdio_shift u_shift
   (
      .wb_clk      (wb_clk),
      .wb_rst      (wb_rst),
      .load_i      (load),
      .op_read_i   (op_read),
      .shift_en_i  (shift_en),
      .sample_en_i (sample_en),
      .fiad_i      (fiad_i),
      .rgad_i      (rgad_i),
      .ctrl_data_i (ctrl_data_i),
      .mdio_in_i   (mdio_in_q),
      .mdio_out_o  (mdio_out),
      .rx_data_o   (prsd_o)
   );

endmodule

// ==== source/mdio_shift.sv ====
module mdio_shift
(
   input  logic                         wb_clk,
   input  logic                         wb_rst,
   input  logic                         load_i,
   input  logic                         op_read_i,
   input  logic                         shift_en_i,
   input  logic                         sample_en_i,
   input  logic [gemac_pkg::PHY_AW-1:0] fiad_i,
   input  logic [gemac_pkg::PHY_AW-1:0] rgad_i,
   input  logic [gemac_pkg::MII_DW-1:0] ctrl_data_i,
   input  logic                         mdio_in_i,
   output logic                         mdio_out_o,
   output logic [gemac_pkg::MII_DW-1:0] rx_data_o
);
   import gemac_pkg::*;

   logic [FRAME_W-1:0] sreg;
   logic [1:0]         opcode;

   assign opcode = op_read_i ? 2'b10 : 2'b01;

   // Output sits at one from load until the first frame bit
   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
         mdio_out_o <= 1'b1;
      else if (load_i)
         mdio_out_o <= 1'b1;
      else if (shift_en_i)
         mdio_out_o <= sreg[FRAME_W-1];
   end

   always_ff @(posedge wb_clk)
   begin
      if (load_i)
         sreg <= {2'b01, opcode, fiad_i, rgad_i, 2'b10, ctrl_data_i};
      else if (shift_en_i)
         sreg <= {sreg[FRAME_W-2:0], 1'b1};      // MSB first
   end

   always_ff @(posedge wb_clk)
   begin
      if (sample_en_i)
         rx_data_o <= {rx_data_o[MII_DW-2:0], mdio_in_i};
   end

endmodule

// ==== source/mdio_ctrl.sv ====
module mdio_ctrl
(
   input  logic wb_clk,
   input  logic wb_rst,
   input  logic mdc_rise_i,
   input  logic mdc_fall_i,
   input  logic nopre_i,
   input  logic wctrl_i,
   input  logic rstat_i,
   input  logic scan_i,
   input  logic rx_bit2_i,
   output logic load_o,
   output logic op_read_o,
   output logic shift_en_o,
   output logic sample_en_o,
   output logic out_en_o,
   output logic busy_o,
   output logic nvalid_o,
   output logic link_fail_o,
   output logic wctrl_start_o,
   output logic rstat_start_o,
   output logic update_rx_o
);
   import gemac_pkg::*;

   typedef enum logic [1:0] {S_IDLE, S_PRE, S_FRAME} state_t;

   state_t           state;
   logic [CNT_W-1:0] cnt;
   logic             op_read;
   logic             op_scan;
   logic             start;
   logic             frame_fall;
   logic             last_fall;

   // Commands are taken on an MDC rising edge only
   assign start      = (state == S_IDLE) & mdc_rise_i & (wctrl_i | rstat_i | scan_i);
   assign frame_fall = (state == S_FRAME) & mdc_fall_i;
   assign last_fall  = frame_fall & (cnt == CNT_W'(FRAME_W));

   assign load_o        = start;
   assign wctrl_start_o = start & wctrl_i;
   assign rstat_start_o = start & ~wctrl_i & rstat_i;
   assign op_read_o     = (state == S_IDLE) ? ~wctrl_i : op_read;
   assign shift_en_o    = frame_fall & (cnt != CNT_W'(FRAME_W));
   assign sample_en_o   = (state == S_FRAME) & mdc_rise_i & op_read & (cnt > DATA_POS);
   assign update_rx_o   = last_fall & op_read;
   assign busy_o        = (state != S_IDLE);

   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
      begin
         state       <= S_IDLE;
         cnt         <= '0;
         op_read     <= 1'b0;
         op_scan     <= 1'b0;
         out_en_o    <= 1'b0;
         nvalid_o    <= 1'b0;
         link_fail_o <= 1'b0;
      end
      else
      begin
         case (state)
            S_IDLE:
            begin
               if (start)
               begin
                  op_read  <= ~wctrl_i;          // Write wins, then read, then scan
                  op_scan  <= ~wctrl_i & ~rstat_i;
                  nvalid_o <= ~wctrl_i & ~rstat_i;
                  out_en_o <= 1'b1;
                  cnt      <= '0;
                  state    <= nopre_i ? S_FRAME : S_PRE;
               end
            end
            S_PRE:
            begin
               if (mdc_fall_i)
               begin
                  if (cnt == CNT_W'(PRE_W - 1))
                  begin
                     cnt   <= '0;
                     state <= S_FRAME;
                  end
                  else
                     cnt <= cnt + 1'b1;
               end
            end
            S_FRAME:
            begin
               if (last_fall)
               begin
                  state    <= S_IDLE;            // Scan restarts from idle if still set
                  out_en_o <= 1'b0;
                  if (op_scan)
                  begin
                     nvalid_o    <= 1'b0;
                     link_fail_o <= ~rx_bit2_i;  // Link status bit of PHY reg 1
                  end
               end
               else if (frame_fall)
               begin
                  cnt <= cnt + 1'b1;
                  if (op_read && (cnt == TA_POS))
                     out_en_o <= 1'b0;           // PHY owns the line from here
               end
            end
            default: state <= S_IDLE;
         endcase
      end
   end

endmodule

// ==== source/mdio_clkgen.sv ====
module mdio_clkgen
(
   input  logic                        wb_clk,
   input  logic                        wb_rst,
   input  logic [gemac_pkg::DIV_W-1:0] divider_i,
   output logic                        mdc_o,
   output logic                        mdc_rise_o,
   output logic                        mdc_fall_o
);
   import gemac_pkg::*;

   logic [DIV_W-1:0] half;
   logic [DIV_W-1:0] cnt;
   logic             next_rise;

   assign half      = (divider_i < DIV_MIN) ? DIV_MIN : divider_i;
   assign next_rise = ~mdc_o;                    // Low now, so rising edge is next

   // Toggle mdc every half period, pulses align with the new level
   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
      begin
         cnt        <= '0;
         mdc_o      <= 1'b0;
         mdc_rise_o <= 1'b0;
         mdc_fall_o <= 1'b0;
      end
      else
      begin
         mdc_rise_o <= 1'b0;
         mdc_fall_o <= 1'b0;
         if (cnt >= half - 1'b1)                 // Also catches a divider cut mid-count
         begin
            cnt        <= '0;
            mdc_o      <= ~mdc_o;
            mdc_rise_o <= next_rise;
            mdc_fall_o <= ~next_rise;
         end
         else
            cnt <= cnt + 1'b1;
      end
   end

endmodule

// ==== source/gemac_pkg.sv ====
package gemac_pkg;

   localparam int WB_AW      = 8;             // Wishbone byte address
   localparam int WB_DW      = 32;
   localparam int REG_AW     = 6;             // Word address, wb_adr[7:2]
   localparam int MII_DW     = 16;            // PHY register data
   localparam int PHY_AW     = 5;             // PHY and register address
   localparam int DIV_W      = 8;             // MDC divider
   localparam int MAC_AW     = 48;            // Station address
   localparam int SETTINGS_W = 6;
   localparam int CMD_W      = 3;             // Write, read, scan
   localparam int FRAME_W    = 32;            // Management frame after preamble
   localparam int PRE_W      = 32;            // Preamble ones
   localparam int CNT_W      = 6;             // Counts up to FRAME_W

   localparam logic [REG_AW-1:0] REG_SETTINGS  = 6'd0;
   localparam logic [REG_AW-1:0] REG_UCAST_H   = 6'd1;
   localparam logic [REG_AW-1:0] REG_UCAST_L   = 6'd2;
   localparam logic [REG_AW-1:0] REG_MCAST_H   = 6'd3;
   localparam logic [REG_AW-1:0] REG_MCAST_L   = 6'd4;
   localparam logic [REG_AW-1:0] REG_MIIMODER  = 6'd5;
   localparam logic [REG_AW-1:0] REG_MIIADDR   = 6'd6;
   localparam logic [REG_AW-1:0] REG_MIIDATA   = 6'd7;
   localparam logic [REG_AW-1:0] REG_MIICMD    = 6'd8;
   localparam logic [REG_AW-1:0] REG_MIISTATUS = 6'd9;
   localparam logic [REG_AW-1:0] REG_MIIRXDATA = 6'd10;

   // ucast, mcast, bcast, pause, all, pause_en
   localparam logic [SETTINGS_W-1:0] SETTINGS_DEFAULT = 6'b111001;

   localparam logic [DIV_W-1:0] DIV_MIN = 8'd2;
   localparam logic [CNT_W-1:0] TA_POS   = 6'd14;  // First turnaround bit
   localparam logic [CNT_W-1:0] DATA_POS = 6'd16;  // First data bit

endpackage
